//--- hdl/rvv_decode_pkg.sv
package rvv_decode_pkg;

  localparam int NUM_DE_UOP      = 2;
  localparam int UOP_INDEX_WIDTH = 3;
  localparam int REG_INDEX_WIDTH = 5;
  localparam int XLEN            = 32;
  localparam int IMM_WIDTH       = 5;
  localparam int VSTART_WIDTH    = 7;
  localparam int EMUL_WIDTH      = 4;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } funct3_e;

  // OPI funct6 codes handled by this decoder
  typedef enum logic [5:0] {
    VADD         = 6'b000000,
    VRSUB        = 6'b000011,
    VAND         = 6'b001001,
    VOR          = 6'b001010,
    VXOR         = 6'b001011,
    VRGATHER     = 6'b001100,
    VSLIDEUP     = 6'b001110,
    VSLIDEDOWN   = 6'b001111,
    VADC         = 6'b010000,
    VMADC        = 6'b010001,
    VMERGE_VMV   = 6'b010111,
    VMSEQ        = 6'b011000,
    VMSNE        = 6'b011001,
    VMSLEU       = 6'b011100,
    VMSLE        = 6'b011101,
    VMSGTU       = 6'b011110,
    VMSGT        = 6'b011111,
    VSADDU       = 6'b100000,
    VSADD        = 6'b100001,
    VSLL         = 6'b100101,
    VSMUL_VMVNRR = 6'b100111,
    VSRL         = 6'b101000,
    VSRA         = 6'b101001,
    VSSRL        = 6'b101010,
    VSSRA        = 6'b101011,
    VNSRL        = 6'b101100,
    VNSRA        = 6'b101101,
    VNCLIPU      = 6'b101110,
    VNCLIP       = 6'b101111
  } opi_funct6_e;

  // low codes follow the vsew encoding
  typedef enum logic [2:0] {
    EEW8  = 3'b000,
    EEW16 = 3'b001,
    EEW32 = 3'b010,
    EEW1  = 3'b111
  } eew_e;

  typedef enum logic [2:0] {
    LMUL1   = 3'b000,
    LMUL2   = 3'b001,
    LMUL4   = 3'b010,
    LMUL8   = 3'b011,
    LMUL1_4 = 3'b110,
    LMUL1_2 = 3'b111
  } lmul_e;

  typedef enum logic {
    ALU    = 1'b0,
    PMTRDT = 1'b1
  } exe_unit_e;

  typedef enum logic {
    VV = 1'b0,
    VX = 1'b1
  } uop_class_e;

  typedef enum logic [2:0] {
    GRP_NONE   = 3'd0,
    GRP_PLAIN  = 3'd1,
    GRP_MASK   = 3'd2,
    GRP_NARROW = 3'd3,
    GRP_MVNR   = 3'd4,
    GRP_PERM   = 3'd5
  } ari_group_e;

  typedef struct packed {
    logic                    vill;
    logic [2:0]              vsew;
    lmul_e                   vlmul;
    logic [VSTART_WIDTH-1:0] vstart;
  } vcsr_t;

  typedef struct packed {
    logic [XLEN-1:0]            pc;
    logic [5:0]                 funct6;
    logic                       vm;
    logic [REG_INDEX_WIDTH-1:0] vs2;
    logic [IMM_WIDTH-1:0]       vs1_imm;
    funct3_e                    funct3;
    logic [REG_INDEX_WIDTH-1:0] vd;
    vcsr_t                      vcsr;
  } inst_t;

  // register group counts are 1, 2, 4 or 8; 0 means no legal group
  typedef struct packed {
    ari_group_e            group;
    logic [EMUL_WIDTH-1:0] emul_vd;
    logic [EMUL_WIDTH-1:0] emul_vs2;
    logic [EMUL_WIDTH-1:0] emul_max;
    eew_e                  eew_vd;
    eew_e                  eew_vs2;
    eew_e                  eew_max;
  } ari_attr_t;

  typedef struct packed {
    logic [XLEN-1:0]            pc;
    funct3_e                    funct3;
    logic [5:0]                 funct6;
    exe_unit_e                  exe_unit;
    uop_class_e                 uop_class;
    vcsr_t                      vcsr;
    logic                       vm;
    logic                       v0_valid;
    logic [REG_INDEX_WIDTH-1:0] vd_index;
    eew_e                       vd_eew;
    logic                       vd_valid;
    logic                       vs3_valid;
    logic [REG_INDEX_WIDTH-1:0] vs1_index;
    eew_e                       vs1_eew;
    logic                       vs1_valid;
    logic [REG_INDEX_WIDTH-1:0] vs2_index;
    eew_e                       vs2_eew;
    logic                       vs2_valid;
    logic [XLEN-1:0]            rs1_data;
    logic                       rs1_valid;
    logic [UOP_INDEX_WIDTH-1:0] uop_index;
    logic                       last_uop;
  } uop_t;

endpackage

//--- hdl/ari_attr_lookup.sv
`timescale 1ns/1ps

module ari_attr_lookup
  import rvv_decode_pkg::*;
(
  input  inst_t     inst,
  output ari_attr_t attr
);

  opi_funct6_e           funct6;
  eew_e                  sew;
  logic [EMUL_WIDTH-1:0] lmul_regs;
  logic [EMUL_WIDTH-1:0] nreg_regs;
  logic [EMUL_WIDTH-1:0] narrow_vs2_regs;

  assign funct6 = opi_funct6_e'(inst.funct6);
  assign sew    = eew_e'(inst.vcsr.vsew);

  always_comb begin
    attr.group = GRP_NONE;
    if (inst.funct3 == OPIVI) begin
      case (funct6)
        VADD, VRSUB, VADC, VAND, VOR, VXOR, VSLL, VSRL, VSRA,
        VMERGE_VMV, VSADDU, VSADD, VSSRL, VSSRA:
          attr.group = GRP_PLAIN;
        VMADC, VMSEQ, VMSNE, VMSLEU, VMSLE, VMSGTU, VMSGT:
          attr.group = GRP_MASK;
        VNSRL, VNSRA, VNCLIPU, VNCLIP:
          attr.group = GRP_NARROW;
        VSMUL_VMVNRR:
          attr.group = GRP_MVNR;
        VSLIDEUP, VSLIDEDOWN, VRGATHER:
          attr.group = GRP_PERM;
        default:
          attr.group = GRP_NONE;
      endcase
    end
  end

  // fractional lmul still occupies one register
  always_comb begin
    case (inst.vcsr.vlmul)
      LMUL2:   lmul_regs = 4'd2;
      LMUL4:   lmul_regs = 4'd4;
      LMUL8:   lmul_regs = 4'd8;
      default: lmul_regs = 4'd1;
    endcase
    case (inst.vcsr.vlmul)
      LMUL1_4, LMUL1_2: narrow_vs2_regs = 4'd1;
      LMUL1:            narrow_vs2_regs = 4'd2;
      LMUL2:            narrow_vs2_regs = 4'd4;
      LMUL4:            narrow_vs2_regs = 4'd8;
      default:          narrow_vs2_regs = 4'd0;
    endcase
    // nr field of vmv<nr>r is nreg-1
    case (inst.vs1_imm[2:0])
      3'd0:    nreg_regs = 4'd1;
      3'd1:    nreg_regs = 4'd2;
      3'd3:    nreg_regs = 4'd4;
      3'd7:    nreg_regs = 4'd8;
      default: nreg_regs = 4'd0;
    endcase
  end

  always_comb begin
    attr.emul_vd  = lmul_regs;
    attr.emul_vs2 = lmul_regs;
    attr.emul_max = lmul_regs;
    attr.eew_vd   = sew;
    attr.eew_vs2  = sew;
    attr.eew_max  = sew;
    case (attr.group)
      GRP_MASK: begin
        attr.emul_vd = 4'd1;
        attr.eew_vd  = EEW1;
      end
      GRP_NARROW: begin
        attr.emul_vs2 = narrow_vs2_regs;
        attr.emul_max = narrow_vs2_regs;
        attr.eew_vs2  = (sew == EEW8) ? EEW16 : EEW32;
        attr.eew_max  = (sew == EEW8) ? EEW16 : EEW32;
      end
      GRP_MVNR: begin
        attr.emul_vd  = nreg_regs;
        attr.emul_vs2 = nreg_regs;
        attr.emul_max = nreg_regs;
      end
      GRP_NONE: begin
        attr.emul_vd  = '0;
        attr.emul_vs2 = '0;
        attr.emul_max = '0;
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/ari_encoding_check.sv
`timescale 1ns/1ps

module ari_encoding_check
  import rvv_decode_pkg::*;
(
  input  inst_t     inst,
  input  ari_attr_t attr,
  output logic      encoding_ok
);

  opi_funct6_e                funct6;
  logic [REG_INDEX_WIDTH-1:0] vd_mask;
  logic [REG_INDEX_WIDTH-1:0] vs2_mask;
  logic                       group_ok;
  logic                       align_ok;
  logic                       overlap;

  assign funct6 = opi_funct6_e'(inst.funct6);

  // low index bits that must be zero for an aligned group
  assign vd_mask  = REG_INDEX_WIDTH'(attr.emul_vd - 4'd1);
  assign vs2_mask = REG_INDEX_WIDTH'(attr.emul_vs2 - 4'd1);

  assign overlap = (inst.vd & ~vs2_mask) == (inst.vs2 & ~vs2_mask);

  always_comb begin
    group_ok = 1'b0;
    case (attr.group)
      GRP_PLAIN: begin
        if (funct6 == VADC) begin
          group_ok = !inst.vm && (inst.vd != '0);
        end else if (funct6 == VMERGE_VMV) begin
          // vmv.v.i form leaves vs2 as zero
          group_ok = !inst.vm || (inst.vs2 == '0);
        end else begin
          group_ok = 1'b1;
        end
      end
      GRP_MASK:
        group_ok = 1'b1;
      GRP_NARROW:
        // only sew8 and sew16 have a wider source
        group_ok = (inst.vcsr.vsew == 3'b000) || (inst.vcsr.vsew == 3'b001);
      GRP_MVNR:
        group_ok = inst.vm && (inst.vs1_imm[4:3] == 2'b00);
      GRP_PERM: begin
        if (funct6 == VSLIDEUP || funct6 == VRGATHER) begin
          group_ok = !overlap;
        end else begin
          group_ok = 1'b1;
        end
      end
      default:
        group_ok = 1'b0;
    endcase
  end

  assign align_ok = ((inst.vd & vd_mask) == '0) && ((inst.vs2 & vs2_mask) == '0);

  // emul_max of 0 covers bad nreg codes and lmul8 narrowing
  assign encoding_ok = group_ok && align_ok && (attr.emul_max != '0);

  // unclassified opcodes carry no register group, so they cannot pass
  always_comb begin
    assert final (!(attr.group == GRP_NONE && attr.emul_max != '0))
      else $error("unclassified funct6 %h has a register group", inst.funct6);
  end

endmodule

//--- hdl/uop_index_seq.sv
`timescale 1ns/1ps

module uop_index_seq
  import rvv_decode_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       inst_valid,
  input  logic [VSTART_WIDTH-1:0]    vstart,
  input  eew_e                       eew_max,
  input  logic                       encoding_ok,
  input  logic                       last_emitted,
  output logic [UOP_INDEX_WIDTH-1:0] uop_index_start,
  output logic [UOP_INDEX_WIDTH-1:0] uop_vstart,
  output logic                       inst_pop,
  output logic                       inst_illegal
);

  // index of the first uop not yet handed out
  logic [UOP_INDEX_WIDTH-1:0] remain;

  always_comb begin
    case (eew_max)
      EEW8:    uop_vstart = vstart[4 +: UOP_INDEX_WIDTH];
      EEW16:   uop_vstart = vstart[3 +: UOP_INDEX_WIDTH];
      EEW32:   uop_vstart = vstart[2 +: UOP_INDEX_WIDTH];
      default: uop_vstart = '0;
    endcase
  end

  assign uop_index_start = (uop_vstart >= remain) ? uop_vstart : remain;

  assign inst_pop     = inst_valid && (last_emitted || !encoding_ok);
  assign inst_illegal = inst_valid && !encoding_ok;

  always_ff @(posedge clk) begin
    if (reset) begin
      remain <= '0;
    end else if (inst_pop) begin
      remain <= '0;
    end else if (inst_valid && encoding_ok && !last_emitted) begin
      remain <= uop_index_start + UOP_INDEX_WIDTH'(NUM_DE_UOP);
    end
  end

  // upstream keeps the instruction until its last uops leave
  a_remain_held: assert property (
    @(posedge clk) disable iff (reset)
    (remain != '0) |-> inst_valid
  ) else $error("instruction dropped with %0d uops pending", remain);

endmodule

//--- hdl/uop_builder.sv
`timescale 1ns/1ps

module uop_builder
  import rvv_decode_pkg::*;
(
  input  logic                       inst_valid,
  input  inst_t                      inst,
  input  ari_attr_t                  attr,
  input  logic                       encoding_ok,
  input  logic [UOP_INDEX_WIDTH-1:0] uop_index_start,
  input  logic [UOP_INDEX_WIDTH-1:0] uop_vstart,
  output logic [NUM_DE_UOP-1:0]      uop_valid,
  output uop_t [NUM_DE_UOP-1:0]      uop,
  output logic                       last_emitted
);

  opi_funct6_e                                funct6;
  logic [NUM_DE_UOP-1:0][UOP_INDEX_WIDTH:0]   uop_index_cur;
  logic [NUM_DE_UOP-1:0]                      uop_last;
  logic [XLEN-1:0]                            imm_sext;
  logic [XLEN-1:0]                            imm_shift;
  logic [XLEN-1:0]                            imm_clip;
  logic [XLEN-1:0]                            imm_zext;
  logic [2:0]                                 vstart_shift;
  logic [REG_INDEX_WIDTH-1:0]                 vd_grp_mask;

  // shift amount uses log2(eew) bits of the immediate
  function automatic logic [IMM_WIDTH-1:0] shamt_mask(eew_e eew);
    case (eew)
      EEW8:    shamt_mask = 5'b00111;
      EEW16:   shamt_mask = 5'b01111;
      default: shamt_mask = 5'b11111;
    endcase
  endfunction

  assign funct6    = opi_funct6_e'(inst.funct6);
  assign imm_sext  = {{(XLEN-IMM_WIDTH){inst.vs1_imm[IMM_WIDTH-1]}}, inst.vs1_imm};
  assign imm_shift = XLEN'(inst.vs1_imm & shamt_mask(attr.eew_vd));
  assign imm_clip  = XLEN'(inst.vs1_imm & shamt_mask(attr.eew_vs2));
  assign imm_zext  = XLEN'(inst.vs1_imm);

  assign vstart_shift = (attr.eew_max == EEW8)  ? 3'd4 :
                        (attr.eew_max == EEW16) ? 3'd3 : 3'd2;

  assign vd_grp_mask = REG_INDEX_WIDTH'(attr.emul_vd - 4'd1);

  always_comb begin
    for (int i = 0; i < NUM_DE_UOP; i++) begin
      uop_index_cur[i] = {1'b0, uop_index_start} + (UOP_INDEX_WIDTH+1)'(i);
      uop_valid[i]     = inst_valid && encoding_ok &&
                         ({1'b0, uop_index_cur[i]} < {1'b0, attr.emul_max});
      uop_last[i]      = {1'b0, uop_index_cur[i]} == ({1'b0, attr.emul_max} - 5'd1);
    end
  end

  assign last_emitted = |(uop_valid & uop_last);

  always_comb begin
    for (int i = 0; i < NUM_DE_UOP; i++) begin
      uop[i].pc        = inst.pc;
      uop[i].funct3    = inst.funct3;
      uop[i].funct6    = inst.funct6;
      uop[i].exe_unit  = (attr.group == GRP_PERM) ? PMTRDT : ALU;
      uop[i].uop_class = (funct6 == VMADC) ? VV : VX;
      uop[i].vcsr      = inst.vcsr;
      uop[i].vm        = inst.vm;
      uop[i].v0_valid  = (funct6 == VADC || funct6 == VMADC) && !inst.vm;
      uop[i].vs3_valid = attr.group == GRP_MASK;
      uop[i].vd_index  = inst.vd + REG_INDEX_WIDTH'(uop_index_cur[i][UOP_INDEX_WIDTH-1:0]);
      uop[i].vd_eew    = attr.eew_vd;
      uop[i].vd_valid  = attr.group != GRP_NONE;
      uop[i].vs1_index = '0;
      uop[i].vs1_eew   = EEW8;
      uop[i].vs1_valid = 1'b0;
      uop[i].vs2_index = inst.vs2 + REG_INDEX_WIDTH'(uop_index_cur[i][UOP_INDEX_WIDTH-1:0]);
      uop[i].vs2_eew   = attr.eew_vs2;
      uop[i].vs2_valid = attr.group != GRP_NONE;
      uop[i].rs1_valid = attr.group != GRP_NONE;
      uop[i].uop_index = uop_index_cur[i][UOP_INDEX_WIDTH-1:0];
      uop[i].last_uop  = uop_last[i];

      case (funct6)
        VSLL, VSRL, VSRA, VNSRL, VNSRA, VSSRL, VSSRA: uop[i].rs1_data = imm_shift;
        VNCLIPU, VNCLIP:                              uop[i].rs1_data = imm_clip;
        VSLIDEUP, VSLIDEDOWN, VRGATHER:               uop[i].rs1_data = imm_zext;
        VSMUL_VMVNRR:                                 uop[i].rs1_data = '0;
        default:                                      uop[i].rs1_data = imm_sext;
      endcase

      case (attr.group)
        GRP_MASK:
          uop[i].vd_index = inst.vd;
        GRP_NARROW:
          // two source registers fold into one destination
          uop[i].vd_index = inst.vd +
                            REG_INDEX_WIDTH'(uop_index_cur[i][UOP_INDEX_WIDTH-1:1]);
        GRP_MVNR: begin
          // whole-register move runs as vmv.v.v per register
          uop[i].funct3    = OPIVV;
          uop[i].funct6    = VMERGE_VMV;
          uop[i].vs1_index = uop[i].vs2_index;
          uop[i].vs1_eew   = attr.eew_vs2;
          uop[i].vs1_valid = 1'b1;
          uop[i].vs2_index = '0;
          uop[i].vs2_valid = 1'b0;
          uop[i].rs1_valid = 1'b0;
        end
        default: ;
      endcase

      // only the uop holding vstart keeps it, the rest start at their boundary
      if (uop_index_cur[i] != {1'b0, uop_vstart}) begin
        uop[i].vcsr.vstart = VSTART_WIDTH'(uop_index_cur[i][UOP_INDEX_WIDTH-1:0]) <<
                             vstart_shift;
      end
    end
  end

  // each valid uop writes inside the aligned vd group
  always_comb begin
    for (int i = 0; i < NUM_DE_UOP; i++) begin
      if (uop_valid[i]) begin
        assert final ((uop[i].vd_index & ~vd_grp_mask) == inst.vd)
          else $error("slot %0d vd_index %0d outside group of v%0d", i,
                      uop[i].vd_index, inst.vd);
      end
    end
  end

endmodule

//--- hdl/rvv_decode_ari.sv
`timescale 1ns/1ps

module rvv_decode_ari
  import rvv_decode_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             inst_valid,
  input  inst_t                            inst,
  output logic [NUM_DE_UOP-1:0]            uop_valid,
  output uop_t [NUM_DE_UOP-1:0]            uop,
  output logic                             inst_pop,
  output logic                             inst_illegal
);

  ari_attr_t                  attr;
  logic                       encoding_ok;
  logic                       last_emitted;
  logic [UOP_INDEX_WIDTH-1:0] uop_index_start;
  logic [UOP_INDEX_WIDTH-1:0] uop_vstart;

  ari_attr_lookup u_attr (
    .inst (inst),
    .attr (attr)
  );

  ari_encoding_check u_check (
    .inst        (inst),
    .attr        (attr),
    .encoding_ok (encoding_ok)
  );

  uop_index_seq u_seq (
    .clk             (clk),
    .reset           (reset),
    .inst_valid      (inst_valid),
    .vstart          (inst.vcsr.vstart),
    .eew_max         (attr.eew_max),
    .encoding_ok     (encoding_ok),
    .last_emitted    (last_emitted),
    .uop_index_start (uop_index_start),
    .uop_vstart      (uop_vstart),
    .inst_pop        (inst_pop),
    .inst_illegal    (inst_illegal)
  );

  uop_builder u_build (
    .inst_valid      (inst_valid),
    .inst            (inst),
    .attr            (attr),
    .encoding_ok     (encoding_ok),
    .uop_index_start (uop_index_start),
    .uop_vstart      (uop_vstart),
    .uop_valid       (uop_valid),
    .uop             (uop),
    .last_emitted    (last_emitted)
  );

endmodule

//--- test/tb_rvv_decode_ari.sv
`timescale 1ns/1ps

module tb_rvv_decode_ari
  import rvv_decode_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int COLS       = 33;
  localparam int MAX_LINES  = 64;

  logic                  clk;
  logic                  reset;
  logic                  inst_valid;
  inst_t                 inst;
  logic [NUM_DE_UOP-1:0] uop_valid;
  uop_t [NUM_DE_UOP-1:0] uop;
  logic                  inst_pop;
  logic                  inst_illegal;

  // word 0 is the line count, then COLS words per cycle
  logic [31:0]     stim_mem [0:COLS*MAX_LINES];
  int              num_lines = 0;
  logic [XLEN-1:0] cur_pc;

  rvv_decode_ari dut0 (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .inst_pop     (inst_pop),
    .inst_illegal (inst_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_field(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERROR %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_valid(input logic [NUM_DE_UOP-1:0] exp, input logic [NUM_DE_UOP-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERROR uop_valid expected %h got %h", exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERROR %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_uop(input int slot, input uop_t exp, input uop_t act);
    string p;
    p = $sformatf("uop[%0d].", slot);
    compare_field({p, "pc"}, exp.pc, act.pc);
    compare_field({p, "funct3"}, XLEN'(exp.funct3), XLEN'(act.funct3));
    compare_field({p, "funct6"}, XLEN'(exp.funct6), XLEN'(act.funct6));
    compare_field({p, "vm"}, XLEN'(exp.vm), XLEN'(act.vm));
    compare_field({p, "v0_valid"}, XLEN'(exp.v0_valid), XLEN'(act.v0_valid));
    compare_field({p, "vs3_valid"}, XLEN'(exp.vs3_valid), XLEN'(act.vs3_valid));
    compare_field({p, "vs2_valid"}, XLEN'(exp.vs2_valid), XLEN'(act.vs2_valid));
    compare_field({p, "vs1_valid"}, XLEN'(exp.vs1_valid), XLEN'(act.vs1_valid));
    compare_field({p, "vd_eew"}, XLEN'(exp.vd_eew), XLEN'(act.vd_eew));
    compare_field({p, "vd_index"}, XLEN'(exp.vd_index), XLEN'(act.vd_index));
    compare_field({p, "vs2_index"}, XLEN'(exp.vs2_index), XLEN'(act.vs2_index));
    compare_field({p, "vs1_index"}, XLEN'(exp.vs1_index), XLEN'(act.vs1_index));
    compare_field({p, "rs1_data"}, exp.rs1_data, act.rs1_data);
    compare_field({p, "exe_unit"}, XLEN'(exp.exe_unit), XLEN'(act.exe_unit));
    compare_field({p, "uop_class"}, XLEN'(exp.uop_class), XLEN'(act.uop_class));
    compare_field({p, "vstart"}, XLEN'(exp.vcsr.vstart), XLEN'(act.vcsr.vstart));
    compare_field({p, "uop_index"}, XLEN'(exp.uop_index), XLEN'(act.uop_index));
    compare_field({p, "last_uop"}, XLEN'(exp.last_uop), XLEN'(act.last_uop));
  endtask

  // expected slot contents from the stim columns
  function automatic uop_t expect_uop(input int base, input int slot);
    uop_t       e;
    int         s;
    logic [3:0] flags;
    e           = '0;
    s           = base + 17 + 8 * slot;
    flags       = stim_mem[base+16][3:0];
    e.pc        = cur_pc;
    e.funct3    = funct3_e'(stim_mem[base+13][2:0]);
    e.funct6    = stim_mem[base+14][5:0];
    e.vm        = stim_mem[base+3][0];
    e.v0_valid  = flags[3];
    e.vs3_valid = flags[2];
    e.vs2_valid = flags[1];
    e.vs1_valid = flags[0];
    e.vd_eew    = eew_e'(stim_mem[base+15][2:0]);
    e.vd_index  = stim_mem[s][REG_INDEX_WIDTH-1:0];
    e.vs2_index = stim_mem[s+1][REG_INDEX_WIDTH-1:0];
    e.vs1_index = stim_mem[s+2][REG_INDEX_WIDTH-1:0];
    e.rs1_data  = stim_mem[s+3];
    e.exe_unit  = exe_unit_e'(stim_mem[s+4][0]);
    // carry-out of vmadc reads a vector operand class
    e.uop_class = (stim_mem[base+2][5:0] == 6'b010001) ? VV : VX;
    e.vcsr.vstart = stim_mem[s+5][VSTART_WIDTH-1:0];
    e.uop_index = stim_mem[s+6][UOP_INDEX_WIDTH-1:0];
    e.last_uop  = stim_mem[s+7][0];
    return e;
  endfunction

  task automatic apply_line(input int base);
    inst_valid       = stim_mem[base][0];
    inst.pc          = cur_pc;
    inst.funct3      = funct3_e'(stim_mem[base+1][2:0]);
    inst.funct6      = stim_mem[base+2][5:0];
    inst.vm          = stim_mem[base+3][0];
    inst.vs2         = stim_mem[base+4][REG_INDEX_WIDTH-1:0];
    inst.vs1_imm     = stim_mem[base+5][IMM_WIDTH-1:0];
    inst.vd          = stim_mem[base+6][REG_INDEX_WIDTH-1:0];
    inst.vcsr.vill   = 1'b0;
    inst.vcsr.vsew   = stim_mem[base+7][2:0];
    inst.vcsr.vlmul  = lmul_e'(stim_mem[base+8][2:0]);
    inst.vcsr.vstart = stim_mem[base+9][VSTART_WIDTH-1:0];
  endtask

  initial begin
    int                    base;
    logic [NUM_DE_UOP-1:0] exp_valid;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    cur_pc     = 32'h0000_1000;
    $readmemh("test/decode_stim.txt", stim_mem);
    if (stim_mem[0] < 1 || stim_mem[0] > MAX_LINES) begin
      stop_on_error("stimulus file does not start with a usable line count");
    end
    num_lines = int'(stim_mem[0]);
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int k = 0; k < num_lines; k++) begin
      base = 1 + k * COLS;
      apply_line(base);
      // sample just before the next edge
      #(CLK_PERIOD - 3);
      exp_valid = stim_mem[base+10][NUM_DE_UOP-1:0];
      check_valid(exp_valid, uop_valid);
      check_flag("inst_pop", stim_mem[base+11][0], inst_pop);
      check_flag("inst_illegal", stim_mem[base+12][0], inst_illegal);
      for (int s = 0; s < NUM_DE_UOP; s++) begin
        if (exp_valid[s]) begin
          check_uop(s, expect_uop(base, s), uop[s]);
        end
      end
      if (stim_mem[base+11][0]) begin
        cur_pc = cur_pc + 32'd4;
      end
      @(posedge clk);
      #1;
    end
    $display("TEST PASSED");
    $finish;
  end

  // watchdog sized from the stimulus length
  initial begin
    wait (num_lines > 0);
    #((num_lines + 12) * CLK_PERIOD);
    $display("simulation ran past its time limit before all stimulus lines were checked");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- test/decode_stim.txt
// first word: number of cycle lines; each line: valid f3 f6 vm vs2 imm vd sew lmul vstart,
// then uvalid pop illegal uf3 uf6 vd_eew flags(v0 vs3 vs2 vs1), then per slot: vd vs2 vs1 rs1 exe vstart idx last
1e
0 0 00 0 00 00 00 0 0 00  0 0 0 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // idle
1 3 00 1 08 1e 04 2 0 00  1 1 0 3 00 2 2  04 08 00 fffffffe 0 00 0 1  00 00 00 00000000 0 00 0 0 // vadd lmul1
1 3 00 1 10 05 08 0 2 00  3 0 0 3 00 0 2  08 10 00 00000005 0 00 0 0  09 11 00 00000005 0 10 1 0 // vadd lmul4
1 3 00 1 10 05 08 0 2 00  3 1 0 3 00 0 2  0a 12 00 00000005 0 20 2 0  0b 13 00 00000005 0 30 3 1
1 3 2c 1 04 15 02 0 0 00  3 1 0 3 2c 0 2  02 04 00 00000005 0 00 0 0  02 05 00 00000005 0 08 1 1 // vnsrl
1 3 18 1 06 1f 01 1 1 00  3 1 0 3 18 7 6  01 06 00 ffffffff 0 00 0 0  01 07 00 ffffffff 0 08 1 1 // vmseq
1 3 27 1 04 01 06 2 0 00  3 1 0 0 17 2 1  06 00 04 00000000 0 00 0 0  07 00 05 00000000 0 04 1 1 // vmv2r
1 3 10 0 08 03 02 0 0 00  1 1 0 3 10 0 a  02 08 00 00000003 0 00 0 1  00 00 00 00000000 0 00 0 0 // vadc
1 3 11 0 02 10 03 2 1 00  3 1 0 3 11 7 e  03 02 00 fffffff0 0 00 0 0  03 03 00 fffffff0 0 04 1 1 // vmadc
1 3 25 1 02 1d 01 1 0 00  1 1 0 3 25 1 2  01 02 00 0000000d 0 00 0 1  00 00 00 00000000 0 00 0 0 // vsll
1 3 2f 1 08 1a 04 1 1 00  3 0 0 3 2f 1 2  04 08 00 0000001a 0 00 0 0  04 09 00 0000001a 0 04 1 0 // vnclip
1 3 2f 1 08 1a 04 1 1 00  3 1 0 3 2f 1 2  05 0a 00 0000001a 0 08 2 0  05 0b 00 0000001a 0 0c 3 1
1 3 03 1 04 07 02 0 1 00  3 1 0 3 03 0 2  02 04 00 00000007 0 00 0 0  03 05 00 00000007 0 10 1 1 // vrsub
1 3 17 0 06 1c 05 0 0 00  1 1 0 3 17 0 2  05 06 00 fffffffc 0 00 0 1  00 00 00 00000000 0 00 0 0 // vmerge
1 3 0e 1 08 13 04 0 1 00  3 1 0 3 0e 0 2  04 08 00 00000013 1 00 0 0  05 09 00 00000013 1 10 1 1 // vslideup
1 3 0c 1 03 1f 02 0 0 00  1 1 0 3 0c 0 2  02 03 00 0000001f 1 00 0 1  00 00 00 00000000 0 00 0 0 // vrgather
0 0 00 0 00 00 00 0 0 00  0 0 0 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // idle
1 3 10 0 08 03 00 0 0 00  0 1 1 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // vadc v0
1 3 00 1 04 01 03 0 1 00  0 1 1 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // odd vd
1 3 0e 1 04 02 04 0 1 00  0 1 1 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // overlap
1 3 27 1 00 02 00 0 0 00  0 1 1 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // nreg
1 3 17 1 01 05 02 0 0 00  0 1 1 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // vmv vs2
1 3 3f 1 00 00 00 0 0 00  0 1 1 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // funct6
1 4 00 1 08 01 04 0 0 00  0 1 1 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // opivx
1 3 00 1 10 02 08 0 2 25  3 1 0 3 00 0 2  0a 12 00 00000002 0 25 2 0  0b 13 00 00000002 0 30 3 1 // vstart
1 3 00 1 10 00 08 0 3 15  3 0 0 3 00 0 2  09 11 00 00000000 0 15 1 0  0a 12 00 00000000 0 20 2 0 // lmul8
1 3 00 1 10 00 08 0 3 15  3 0 0 3 00 0 2  0b 13 00 00000000 0 30 3 0  0c 14 00 00000000 0 40 4 0
1 3 00 1 10 00 08 0 3 15  3 0 0 3 00 0 2  0d 15 00 00000000 0 50 5 0  0e 16 00 00000000 0 60 6 0
1 3 00 1 10 00 08 0 3 15  1 1 0 3 00 0 2  0f 17 00 00000000 0 70 7 1  00 00 00 00000000 0 00 0 0
0 0 00 0 00 00 00 0 0 00  0 0 0 0 00 0 0  00 00 00 00000000 0 00 0 0  00 00 00 00000000 0 00 0 0 // idle

//--- list.f
hdl/rvv_decode_pkg.sv
hdl/ari_attr_lookup.sv
hdl/ari_encoding_check.sv
hdl/uop_index_seq.sv
hdl/uop_builder.sv
hdl/rvv_decode_ari.sv
test/tb_rvv_decode_ari.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the OPIVI decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_rvv_decode_ari \
  -Mdir "$BUILD_DIR" \
  -f list.f

# a failing run ends in $fatal, the log decides the verdict
"./$BUILD_DIR/Vtb_rvv_decode_ari" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST PASSED" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
